// File: hdl/bru_pkg.sv
// Shared widths, word and tag types for the branch resolution unit
// Opcode enum for branches, jumps and AUIPC

package bru_pkg;

    // --------------------
    // Widths and counts

    // Data and PC width
    localparam int XLEN = 32;

    // Fall-through distance to the next instruction
    localparam int INSTR_BYTES = 4;

    // Register file organization
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_READ_PORTS = 2;

    localparam int LOG_PR_COUNT = 7;
    localparam int LOG_ROB_ENTRIES = 6;

    // --------------------
    // Types

    typedef logic [XLEN-1:0] word_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
    typedef logic [LOG_PR_COUNT-1:0] pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;

    // Upper bit set marks a conditional branch
    typedef enum logic [3:0] {
        OP_JALR  = 4'b0000,
        OP_JAL   = 4'b0001,
        OP_AUIPC = 4'b0100,
        OP_BEQ   = 4'b1000,
        OP_BNE   = 4'b1001,
        OP_BLT   = 4'b1100,
        OP_BGE   = 4'b1101,
        OP_BLTU  = 4'b1110,
        OP_BGEU  = 4'b1111
    } bru_op_e;

endpackage

// File: hdl/bru_operand_collect.sv
// Operand collect stage of the branch resolution unit
// Tracks operand presence, saves early operands, selects operand sources
// and decides when the op launches into execute

`timescale 1ns/100ps

module bru_operand_collect import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,

    // Issue from the issue queue
    input  logic      issue_valid,
    input  bru_op_e   issue_op,
    input  word_t     issue_PC,
    input  word_t     issue_pred_PC,
    input  word_t     issue_imm,
    input  logic      issue_A_unneeded,
    input  logic      issue_A_forward,
    input  bank_t     issue_A_bank,
    input  logic      issue_B_unneeded,
    input  logic      issue_B_forward,
    input  bank_t     issue_B_bank,
    input  pr_t       issue_dest_PR,
    input  rob_idx_t  issue_ROB_index,
    output logic      issue_ready,

    // Register file reads and forward bus
    input  logic      A_reg_read_ack,
    input  logic      A_reg_read_port,
    input  logic      B_reg_read_ack,
    input  logic      B_reg_read_port,
    input  word_t [PRF_BANK_COUNT-1:0][PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port,
    input  word_t [PRF_BANK_COUNT-1:0] forward_data_by_bank,

    // Back-pressure from execute
    input  logic      ex_hold,

    // Launch into execute
    output logic      oc_launch,
    output bru_op_e   oc_op,
    output word_t     oc_PC,
    output word_t     oc_pred_PC,
    output word_t     oc_imm,
    output word_t     oc_A,
    output word_t     oc_B,
    output pr_t       oc_dest_PR,
    output rob_idx_t  oc_ROB_index
);

    // --------------------
    // OC state

    logic valid_oc;
    logic a_unneeded, a_forward, a_saved;
    logic b_unneeded, b_forward, b_saved;
    bank_t a_bank, b_bank;

    word_t a_saved_data, b_saved_data;
    word_t a_val, b_val;

    logic a_present, b_present;

    // Control flags reset to empty
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_oc <= 1'b0;
            a_unneeded <= 1'b0;
            a_forward <= 1'b0;
            a_saved <= 1'b0;
            b_unneeded <= 1'b0;
            b_forward <= 1'b0;
            b_saved <= 1'b0;
        end else if (issue_ready) begin
            valid_oc <= issue_valid;
            a_unneeded <= issue_A_unneeded;
            a_forward <= issue_A_forward;
            a_saved <= 1'b0;
            b_unneeded <= issue_B_unneeded;
            b_forward <= issue_B_forward;
            b_saved <= 1'b0;
        end else begin
            // Anything that arrived this cycle is now held locally
            a_saved <= a_saved | a_forward | A_reg_read_ack;
            a_forward <= 1'b0;
            b_saved <= b_saved | b_forward | B_reg_read_ack;
            b_forward <= 1'b0;
        end
    end

    // Op payload
    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            oc_op <= issue_op;
            oc_PC <= issue_PC;
            oc_pred_PC <= issue_pred_PC;
            oc_imm <= issue_imm;
            a_bank <= issue_A_bank;
            b_bank <= issue_B_bank;
            oc_dest_PR <= issue_dest_PR;
            oc_ROB_index <= issue_ROB_index;
        end
    end

    // --------------------
    // Operand selection

    always_comb begin
        if (a_saved) begin
            a_val = a_saved_data;
        end else if (a_forward) begin
            a_val = forward_data_by_bank[a_bank];
        end else begin
            a_val = reg_read_data_by_bank_by_port[a_bank][A_reg_read_port];
        end

        if (b_saved) begin
            b_val = b_saved_data;
        end else if (b_forward) begin
            b_val = forward_data_by_bank[b_bank];
        end else begin
            b_val = reg_read_data_by_bank_by_port[b_bank][B_reg_read_port];
        end
    end

    // Recirculates once saved, since the mux then picks the saved copy
    always_ff @(posedge CLK) begin
        a_saved_data <= a_val;
        b_saved_data <= b_val;
    end

    assign oc_A = a_val;
    assign oc_B = b_val;

    // --------------------
    // Launch control

    assign a_present = a_unneeded | a_saved | a_forward | A_reg_read_ack;
    assign b_present = b_unneeded | b_saved | b_forward | B_reg_read_ack;

    assign oc_launch = valid_oc & a_present & b_present & ~ex_hold;
    assign issue_ready = ~valid_oc | oc_launch;

    // PRF only acknowledges reads for an op waiting here
    assert property (@(posedge CLK) disable iff (!nRST)
        (A_reg_read_ack | B_reg_read_ack) |-> valid_oc);

endmodule

// File: hdl/bru_execute.sv
// Execute stage of the branch resolution unit
// EX register, target adders, branch conditions and per-opcode resolution

`timescale 1ns/100ps

module bru_execute import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,

    // From operand collect
    input  logic      oc_launch,
    input  bru_op_e   oc_op,
    input  word_t     oc_PC,
    input  word_t     oc_pred_PC,
    input  word_t     oc_imm,
    input  word_t     oc_A,
    input  word_t     oc_B,
    input  pr_t       oc_dest_PR,
    input  rob_idx_t  oc_ROB_index,

    // Stall handshake with writeback and OC
    input  logic      wb_stall,
    output logic      ex_hold,

    // Register writeback request
    output logic      wb_req,
    output word_t     wb_req_data,
    output pr_t       wb_req_PR,
    output rob_idx_t  wb_req_ROB_index,

    // Branch notification request
    output logic      notif_req,
    output logic      notif_mispredict,
    output logic      notif_taken,
    output word_t     notif_start_PC,
    output word_t     notif_target_PC,
    output rob_idx_t  notif_ROB_index
);

    logic valid_ex;
    bru_op_e op_ex;
    word_t pc_ex, pred_pc_ex, imm_ex, a_ex, b_ex;

    word_t pc_plus_4, pc_plus_imm, a_plus_imm;
    logic br_cond;

    // --------------------
    // EX register

    assign ex_hold = valid_ex & wb_stall;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_ex <= 1'b0;
        end else if (!ex_hold) begin
            valid_ex <= oc_launch;
        end
    end

    always_ff @(posedge CLK) begin
        if (!ex_hold) begin
            op_ex <= oc_op;
            pc_ex <= oc_PC;
            pred_pc_ex <= oc_pred_PC;
            imm_ex <= oc_imm;
            a_ex <= oc_A;
            b_ex <= oc_B;
            wb_req_PR <= oc_dest_PR;
            wb_req_ROB_index <= oc_ROB_index;
        end
    end

    // --------------------
    // Resolution

    assign pc_plus_4 = pc_ex + word_t'(INSTR_BYTES);
    assign pc_plus_imm = pc_ex + imm_ex;
    assign a_plus_imm = a_ex + imm_ex;

    always_comb begin
        case (op_ex)
            OP_BEQ:  br_cond = (a_ex == b_ex);
            OP_BNE:  br_cond = (a_ex != b_ex);
            OP_BLT:  br_cond = ($signed(a_ex) < $signed(b_ex));
            OP_BGE:  br_cond = ($signed(a_ex) >= $signed(b_ex));
            OP_BLTU: br_cond = (a_ex < b_ex);
            OP_BGEU: br_cond = (a_ex >= b_ex);
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        wb_req = 1'b0;
        wb_req_data = pc_plus_4;
        notif_req = 1'b0;
        notif_taken = 1'b0;
        notif_target_PC = pc_plus_4;
        case (op_ex)
            OP_JALR: begin
                wb_req = valid_ex;
                notif_req = valid_ex;
                notif_taken = 1'b1;
                notif_target_PC = a_plus_imm;
            end
            OP_JAL: begin
                wb_req = valid_ex;
                notif_req = valid_ex;
                notif_taken = 1'b1;
                notif_target_PC = pc_plus_imm;
            end
            OP_AUIPC: begin
                wb_req = valid_ex;
                wb_req_data = pc_plus_imm;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                notif_req = valid_ex;
                notif_taken = br_cond;
                notif_target_PC = br_cond ? pc_plus_imm : pc_plus_4;
            end
            default: begin
                // Undefined opcode resolves to nothing
                wb_req = 1'b0;
                notif_req = 1'b0;
            end
        endcase
    end

    // Mispredict compares the prediction with the resolved next PC
    assign notif_mispredict = (pred_pc_ex != notif_target_PC);
    assign notif_start_PC = pc_ex;
    assign notif_ROB_index = wb_req_ROB_index;

    // Issue queue only hands over the nine supported ops
    assert property (@(posedge CLK) disable iff (!nRST)
        valid_ex |-> op_ex inside {OP_JALR, OP_JAL, OP_AUIPC, OP_BEQ, OP_BNE,
                                   OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});

endmodule

// File: hdl/bru_writeback.sv
// Writeback stage of the branch resolution unit
// Output registers for PRF writeback and ROB branch notification,
// plus the stall that propagates back up the pipeline

`timescale 1ns/100ps

module bru_writeback import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,

    // Requests from execute
    input  logic      wb_req,
    input  word_t     wb_req_data,
    input  pr_t       wb_req_PR,
    input  rob_idx_t  wb_req_ROB_index,
    input  logic      notif_req,
    input  logic      notif_mispredict,
    input  logic      notif_taken,
    input  word_t     notif_start_PC,
    input  word_t     notif_target_PC,
    input  rob_idx_t  notif_ROB_index,

    // Back-pressure
    input  logic      WB_ready,
    input  logic      branch_notif_ready,
    output logic      wb_stall,

    // Writeback to PRF
    output logic      WB_valid,
    output word_t     WB_data,
    output pr_t       WB_PR,
    output rob_idx_t  WB_ROB_index,

    // Branch notification to ROB
    output logic      branch_notif_valid,
    output rob_idx_t  branch_notif_ROB_index,
    output logic      branch_notif_mispredict,
    output logic      branch_notif_taken,
    output word_t     branch_notif_start_PC,
    output word_t     branch_notif_target_PC
);

    assign wb_stall = (WB_valid & ~WB_ready) | (branch_notif_valid & ~branch_notif_ready);

    // --------------------
    // Valids

    // While stalled, a side already taken drops and its partner waits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            WB_valid <= 1'b0;
            branch_notif_valid <= 1'b0;
        end else if (wb_stall) begin
            WB_valid <= WB_valid & ~WB_ready;
            branch_notif_valid <= branch_notif_valid & ~branch_notif_ready;
        end else begin
            WB_valid <= wb_req;
            branch_notif_valid <= notif_req;
        end
    end

    // --------------------
    // Payload

    always_ff @(posedge CLK) begin
        if (!wb_stall) begin
            WB_data <= wb_req_data;
            WB_PR <= wb_req_PR;
            WB_ROB_index <= wb_req_ROB_index;
            branch_notif_ROB_index <= notif_ROB_index;
            branch_notif_mispredict <= notif_mispredict;
            branch_notif_taken <= notif_taken;
            branch_notif_start_PC <= notif_start_PC;
            branch_notif_target_PC <= notif_target_PC;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        (WB_valid & ~WB_ready) |=> WB_valid && $stable(WB_data) && $stable(WB_PR));

    assert property (@(posedge CLK) disable iff (!nRST)
        (branch_notif_valid & ~branch_notif_ready) |=> branch_notif_valid
            && $stable(branch_notif_target_PC) && $stable(branch_notif_ROB_index));

endmodule

// File: hdl/bru_pipeline.sv
// Top level of the branch resolution unit
// Operand collect, execute and writeback stages wired in sequence

`timescale 1ns/100ps

module bru_pipeline import bru_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,

    // Issue port
    input  logic      issue_valid,
    input  bru_op_e   issue_op,
    input  word_t     issue_PC,
    input  word_t     issue_pred_PC,
    input  word_t     issue_imm,
    input  logic      issue_A_unneeded,
    input  logic      issue_A_forward,
    input  bank_t     issue_A_bank,
    input  logic      issue_B_unneeded,
    input  logic      issue_B_forward,
    input  bank_t     issue_B_bank,
    input  pr_t       issue_dest_PR,
    input  rob_idx_t  issue_ROB_index,
    output logic      issue_ready,

    // PRF reads and forward bus
    input  logic      A_reg_read_ack,
    input  logic      A_reg_read_port,
    input  logic      B_reg_read_ack,
    input  logic      B_reg_read_port,
    input  word_t [PRF_BANK_COUNT-1:0][PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port,
    input  word_t [PRF_BANK_COUNT-1:0] forward_data_by_bank,

    // PRF writeback
    output logic      WB_valid,
    output word_t     WB_data,
    output pr_t       WB_PR,
    output rob_idx_t  WB_ROB_index,
    input  logic      WB_ready,

    // ROB branch notification
    output logic      branch_notif_valid,
    output rob_idx_t  branch_notif_ROB_index,
    output logic      branch_notif_mispredict,
    output logic      branch_notif_taken,
    output word_t     branch_notif_start_PC,
    output word_t     branch_notif_target_PC,
    input  logic      branch_notif_ready
);

    // --------------------
    // OC to EX

    logic oc_launch;
    bru_op_e oc_op;
    word_t oc_PC, oc_pred_PC, oc_imm, oc_A, oc_B;
    pr_t oc_dest_PR;
    rob_idx_t oc_ROB_index;
    logic ex_hold;

    // --------------------
    // EX to WB

    logic wb_req;
    word_t wb_req_data;
    pr_t wb_req_PR;
    rob_idx_t wb_req_ROB_index;
    logic notif_req, notif_mispredict, notif_taken;
    word_t notif_start_PC, notif_target_PC;
    rob_idx_t notif_ROB_index;
    logic wb_stall;

    bru_operand_collect oc_inst (.*);

    bru_execute ex_inst (.*);

    bru_writeback wb_inst (.*);

endmodule

// File: testbench/bru_tb_tasks.svh
// Directed test tasks for the branch resolution unit testbench
// Reference resolution, LFSR words, issue driver and output drain

`ifndef BRU_TB_TASKS_SVH
`define BRU_TB_TASKS_SVH

// Galois LFSR stepped once per bit taken
function automatic logic next_rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return lsb;
endfunction

function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < XLEN; i++) begin
        w = {w[XLEN-2:0], next_rand_bit()};
    end
    return w;
endfunction

// Expected result of one op from the resolution rules
function automatic void resolve_ref(input bru_op_e op, input word_t pc, pred, imm, a, b,
                                    output logic has_wb, output word_t wb_data,
                                    output logic has_notif, taken, mispredict,
                                    output word_t target);
    logic cond;
    cond = 1'b0;
    has_wb = (op == OP_JAL) || (op == OP_JALR) || (op == OP_AUIPC);
    has_notif = (op != OP_AUIPC);
    wb_data = (op == OP_AUIPC) ? pc + imm : pc + 32'd4;
    case (op)
        OP_BEQ: cond = (a == b);
        OP_BNE: cond = (a != b);
        OP_BLT: cond = ($signed(a) < $signed(b));
        OP_BGE: cond = !($signed(a) < $signed(b));
        OP_BLTU: cond = (a < b);
        OP_BGEU: cond = !(a < b);
        default: cond = 1'b1;
    endcase
    taken = cond;
    if (op == OP_JALR) begin
        target = a + imm;
    end else begin
        target = cond ? pc + imm : pc + 32'd4;
    end
    mispredict = (pred != target);
endfunction

// Called 2 ns after a rising edge and returns 2 ns after the acceptance edge
task automatic issue(input bru_op_e op, input word_t pc, pred, imm, a, b,
                     input logic [1:0] a_src, b_src);
    logic hw, hn, tk, mp;
    word_t wd, tg;
    rob_idx_t rob;
    rob = next_rob;
    next_rob = next_rob + 6'd1;
    resolve_ref(op, pc, pred, imm, a, b, hw, wd, hn, tk, mp, tg);
    if (hw) begin
        wb_q.push_back('{data: wd, pr: {1'b1, rob}, rob: rob});
    end
    if (hn) begin
        notif_q.push_back('{rob: rob, mispredict: mp, taken: tk, start_pc: pc, target_pc: tg});
    end
    issue_valid = 1'b1;
    issue_op = op;
    issue_PC = pc;
    issue_pred_PC = pred;
    issue_imm = imm;
    issue_A_unneeded = (a_src == SRC_UNN);
    issue_A_forward = (a_src == SRC_FWD);
    issue_A_bank = rob[1:0];
    issue_B_unneeded = (b_src == SRC_UNN);
    issue_B_forward = (b_src == SRC_FWD);
    issue_B_bank = ~rob[1:0];
    issue_dest_PR = {1'b1, rob};
    issue_ROB_index = rob;
    do begin
        @(negedge CLK);
    end while (!issue_ready);
    @(posedge CLK);
    #2;
    issue_valid = 1'b0;
    // Forward bus carries the operands during the first OC cycle
    if (a_src == SRC_FWD) begin
        forward_data_by_bank[rob[1:0]] = a;
    end
    if (b_src == SRC_FWD) begin
        forward_data_by_bank[~rob[1:0]] = b;
    end
endtask

// Wait until every expected output was seen and then idle a few cycles
task automatic drain();
    while (wb_q.size() != 0 || notif_q.size() != 0) begin
        @(posedge CLK);
    end
    repeat (4) @(posedge CLK);
    #2;
endtask

task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, errors - err_before);
    end
endtask

// ---------------------
// Directed tests

task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge CLK);
    if (WB_valid !== 1'b0) begin
        $display("Fail WB_valid got %h expected %h", WB_valid, 1'b0);
        errors++;
    end
    if (branch_notif_valid !== 1'b0) begin
        $display("Fail branch_notif_valid got %h expected %h", branch_notif_valid, 1'b0);
        errors++;
    end
    if (issue_ready !== 1'b1) begin
        $display("Fail issue_ready got %h expected %h", issue_ready, 1'b1);
        errors++;
    end
    @(posedge CLK);
    #2;
    report("reset", e0);
endtask

task automatic test_jumps();
    int e0;
    bru_op_e ops[3];
    word_t pc, imm, a, pred;
    e0 = errors;
    ops[0] = OP_JAL;
    ops[1] = OP_JALR;
    ops[2] = OP_AUIPC;
    for (int i = 0; i < 3; i++) begin
        for (int k = 0; k < 3; k++) begin
            pc = rand_word() & 32'hFFFF_FFFC;
            imm = rand_word();
            a = rand_word();
            pred = (k == 0) ? pc + imm : (k == 1) ? a + imm : pc + 32'd4;
            issue(ops[i], pc, pred, imm, a, rand_word(), SRC_FWD, SRC_FWD);
        end
    end
    // Both operands unneeded launch with no acknowledge at all
    pc = rand_word() & 32'hFFFF_FFFC;
    imm = rand_word();
    issue(OP_JAL, pc, pc + imm, imm, '0, '0, SRC_UNN, SRC_UNN);
    drain();
    report("jumps", e0);
endtask

task automatic test_branches();
    int e0;
    bru_op_e conds[6];
    word_t pc, imm, a, b;
    e0 = errors;
    conds[0] = OP_BEQ;
    conds[1] = OP_BNE;
    conds[2] = OP_BLT;
    conds[3] = OP_BGE;
    conds[4] = OP_BLTU;
    conds[5] = OP_BGEU;
    for (int i = 0; i < 6; i++) begin
        for (int p = 0; p < 4; p++) begin
            pc = rand_word() & 32'hFFFF_FFFC;
            imm = rand_word() & 32'h0000_1FFC;
            a = rand_word();
            b = rand_word();
            if (p == 1) begin
                b = a;
            end else if (p == 2) begin
                a = 32'h8000_0000;
                b = 32'h7FFF_FFFF;
            end else if (p == 3) begin
                a = 32'h7FFF_FFFF;
                b = 32'h8000_0000;
            end
            issue(conds[i], pc, (p % 2 == 0) ? pc + 32'd4 : pc + imm, imm, a, b,
                  SRC_FWD, SRC_FWD);
        end
    end
    drain();
    report("branches", e0);
endtask

task automatic read_both(input bru_op_e op, input word_t pc, imm, a, b);
    bank_t ab, bb;
    ab = next_rob[1:0];
    bb = ~next_rob[1:0];
    issue(op, pc, a + imm, imm, a, b, SRC_REG, SRC_REG);
    reg_read_data_by_bank_by_port[ab][1] = a;
    A_reg_read_port = 1'b1;
    A_reg_read_ack = 1'b1;
    for (int i = 0; i < 4; i++) begin
        @(negedge CLK);
        if (issue_ready !== 1'b0) begin
            $display("Fail issue_ready got %h expected %h", issue_ready, 1'b0);
            errors++;
        end
        @(posedge CLK);
        #2;
        A_reg_read_ack = 1'b0;
        reg_read_data_by_bank_by_port[ab][1] = ~a;
    end
    reg_read_data_by_bank_by_port[bb][0] = b;
    B_reg_read_port = 1'b0;
    B_reg_read_ack = 1'b1;
    @(negedge CLK);
    if (issue_ready !== 1'b1) begin
        $display("Fail issue_ready got %h expected %h", issue_ready, 1'b1);
        errors++;
    end
    @(posedge CLK);
    #2;
    B_reg_read_ack = 1'b0;
endtask

task automatic test_reg_read();
    int e0;
    e0 = errors;
    read_both(OP_JALR, 32'h0000_4000, 32'h0000_0010, rand_word(), rand_word());
    read_both(OP_BLT, 32'h0000_5000, 32'h0000_0040, 32'hFFFF_FFF0, 32'h0000_0003);
    read_both(OP_BGEU, 32'h0000_6000, 32'h0000_0080, rand_word(), rand_word());
    drain();
    report("register read", e0);
endtask

task automatic test_backpressure(input logic hold_wb, input logic hold_nt);
    int e0;
    logic saw_low, wb_held, nt_held;
    word_t wb_prev, nt_prev;
    e0 = errors;
    saw_low = 1'b0;
    wb_held = 1'b0;
    nt_held = 1'b0;
    wb_prev = '0;
    nt_prev = '0;
    WB_ready = ~hold_wb;
    branch_notif_ready = ~hold_nt;
    fork
        begin
            issue(OP_BEQ, 32'h100, 32'h104, 32'h20, 32'd5, 32'd5, SRC_FWD, SRC_FWD);
            issue(OP_JAL, 32'h200, 32'h240, 32'h40, '0, '0, SRC_UNN, SRC_UNN);
            issue(OP_AUIPC, 32'h300, 32'h304, 32'h1000, '0, '0, SRC_UNN, SRC_UNN);
            issue(OP_BGEU, 32'h400, 32'h404, 32'h8, rand_word(), rand_word(), SRC_FWD, SRC_FWD);
            issue(OP_JALR, 32'h500, 32'h504, 32'hC, rand_word(), '0, SRC_FWD, SRC_UNN);
            issue(OP_BNE, 32'h600, 32'h604, 32'h10, 32'd1, 32'd2, SRC_FWD, SRC_FWD);
        end
        begin
            repeat (16) begin
                @(negedge CLK);
                if (!issue_ready) begin
                    saw_low = 1'b1;
                end
                if (WB_valid && !WB_ready) begin
                    if (wb_held && WB_data !== wb_prev) begin
                        $display("Fail WB_data got %h expected %h", WB_data, wb_prev);
                        errors++;
                    end
                    wb_held = 1'b1;
                    wb_prev = WB_data;
                end
                if (branch_notif_valid && !branch_notif_ready) begin
                    if (nt_held && branch_notif_target_PC !== nt_prev) begin
                        $display("Fail branch_notif_target_PC got %h expected %h",
                                 branch_notif_target_PC, nt_prev);
                        errors++;
                    end
                    nt_held = 1'b1;
                    nt_prev = branch_notif_target_PC;
                end
            end
            @(posedge CLK);
            #2;
            WB_ready = 1'b1;
            branch_notif_ready = 1'b1;
        end
    join
    if (!saw_low) begin
        $display("issue_ready never fell while the outputs were held");
        errors++;
    end
    drain();
    report("back-pressure", e0);
endtask

`endif

// File: testbench/bru_pipeline_tb.sv
// Testbench for the branch resolution unit pipeline
// Clock, reset, register file and forward bus models, LFSR, output
// scoreboard, timeout and the directed test sequence

`timescale 1ns/100ps

module bru_pipeline_tb import bru_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_CYCLES = 2000;

    // Operand source codes used by the issue task
    localparam logic [1:0] SRC_FWD = 2'd0;
    localparam logic [1:0] SRC_UNN = 2'd1;
    localparam logic [1:0] SRC_REG = 2'd2;

    typedef struct packed {
        word_t data;
        pr_t pr;
        rob_idx_t rob;
    } wb_exp_t;

    typedef struct packed {
        rob_idx_t rob;
        logic mispredict;
        logic taken;
        word_t start_pc;
        word_t target_pc;
    } notif_exp_t;

    logic CLK;
    logic nRST;

    logic issue_valid;
    bru_op_e issue_op;
    word_t issue_PC, issue_pred_PC, issue_imm;
    logic issue_A_unneeded, issue_A_forward;
    bank_t issue_A_bank;
    logic issue_B_unneeded, issue_B_forward;
    bank_t issue_B_bank;
    pr_t issue_dest_PR;
    rob_idx_t issue_ROB_index;
    logic issue_ready;

    logic A_reg_read_ack, A_reg_read_port, B_reg_read_ack, B_reg_read_port;
    word_t [PRF_BANK_COUNT-1:0][PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port;
    word_t [PRF_BANK_COUNT-1:0] forward_data_by_bank;

    logic WB_valid, WB_ready;
    word_t WB_data;
    pr_t WB_PR;
    rob_idx_t WB_ROB_index;

    logic branch_notif_valid, branch_notif_ready;
    rob_idx_t branch_notif_ROB_index;
    logic branch_notif_mispredict, branch_notif_taken;
    word_t branch_notif_start_PC, branch_notif_target_PC;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    rob_idx_t next_rob = '0;
    logic [15:0] lfsr_state = 16'd61565;

    wb_exp_t wb_q[$];
    notif_exp_t notif_q[$];

    bru_pipeline bru_pipeline_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // --------------------
    // Scoreboard sampled mid-cycle where everything is settled

    always @(negedge CLK) begin
        wb_exp_t ew;
        notif_exp_t en;
        if (nRST && WB_valid && WB_ready) begin
            if (wb_q.size() == 0) begin
                $display("Unexpected writeback for ROB index %h", WB_ROB_index);
                errors++;
            end else begin
                ew = wb_q.pop_front();
                if (WB_ROB_index !== ew.rob) begin
                    $display("Fail WB_ROB_index got %h expected %h", WB_ROB_index, ew.rob);
                    errors++;
                end
                if (WB_data !== ew.data) begin
                    $display("Fail WB_data got %h expected %h", WB_data, ew.data);
                    errors++;
                end
                if (WB_PR !== ew.pr) begin
                    $display("Fail WB_PR got %h expected %h", WB_PR, ew.pr);
                    errors++;
                end
            end
        end
        if (nRST && branch_notif_valid && branch_notif_ready) begin
            if (notif_q.size() == 0) begin
                $display("Unexpected branch notification for ROB index %h",
                         branch_notif_ROB_index);
                errors++;
            end else begin
                en = notif_q.pop_front();
                if (branch_notif_ROB_index !== en.rob) begin
                    $display("Fail branch_notif_ROB_index got %h expected %h",
                             branch_notif_ROB_index, en.rob);
                    errors++;
                end
                if (branch_notif_taken !== en.taken) begin
                    $display("Fail branch_notif_taken got %h expected %h",
                             branch_notif_taken, en.taken);
                    errors++;
                end
                if (branch_notif_mispredict !== en.mispredict) begin
                    $display("Fail branch_notif_mispredict got %h expected %h",
                             branch_notif_mispredict, en.mispredict);
                    errors++;
                end
                if (branch_notif_start_PC !== en.start_pc) begin
                    $display("Fail branch_notif_start_PC got %h expected %h",
                             branch_notif_start_PC, en.start_pc);
                    errors++;
                end
                if (branch_notif_target_PC !== en.target_pc) begin
                    $display("Fail branch_notif_target_PC got %h expected %h",
                             branch_notif_target_PC, en.target_pc);
                    errors++;
                end
            end
        end
    end

    // Run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    `include "bru_tb_tasks.svh"

    // --------------------
    // Test sequence

    initial begin
        nRST = 1'b0;
        issue_valid = 1'b0;
        issue_op = OP_JAL;
        issue_PC = '0;
        issue_pred_PC = '0;
        issue_imm = '0;
        issue_A_unneeded = 1'b0;
        issue_A_forward = 1'b0;
        issue_A_bank = '0;
        issue_B_unneeded = 1'b0;
        issue_B_forward = 1'b0;
        issue_B_bank = '0;
        issue_dest_PR = '0;
        issue_ROB_index = '0;
        A_reg_read_ack = 1'b0;
        A_reg_read_port = 1'b0;
        B_reg_read_ack = 1'b0;
        B_reg_read_port = 1'b0;
        reg_read_data_by_bank_by_port = '0;
        forward_data_by_bank = '0;
        WB_ready = 1'b1;
        branch_notif_ready = 1'b1;

        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;

        test_reset();
        test_jumps();
        test_branches();
        test_reg_read();
        test_backpressure(1'b1, 1'b0);
        test_backpressure(1'b0, 1'b1);
        test_backpressure(1'b1, 1'b1);

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+testbench
hdl/bru_pkg.sv
hdl/bru_operand_collect.sv
hdl/bru_execute.sv
hdl/bru_writeback.sv
hdl/bru_pipeline.sv
testbench/bru_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= bru_pipeline_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
